// File: source/hub_cfg_pkg.sv
`default_nettype none

package hub_cfg_pkg;

    // --------------------
    // hub structure
    // --------------------

    // peer requesters sharing the scratchpad
    localparam int num_ports = 2;

    // width of a port number on grant and response paths
    localparam int port_idx_width = 1;

endpackage

`default_nettype wire

// File: source/hub_mem_pkg.sv
`default_nettype none

package hub_mem_pkg;

    // --------------------
    // scratchpad geometry
    // --------------------

    localparam int addr_width = 8;
    localparam int data_width = 16;
    localparam int tag_width  = 8;

    // --------------------
    // request word
    // --------------------

    // write view holds address and store data
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
    } req_write_t;

    // read view keeps the address where the write view has it
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [tag_width-1:0]  tag;
        logic [7:0]            pad;
    } req_read_t;

    // one word decoded by the op bit that travels next to it
    typedef union packed {
        req_write_t wr;
        req_read_t  rd;
    } req_word_t;

    // queue entry is op bit plus request word
    localparam int queue_width = 1 + $bits(req_word_t);

endpackage

`default_nettype wire

// File: source/request_queue.sv
`timescale 1ns/1ns
`default_nettype none

module request_queue #(
    parameter int data_width = 1,
    parameter int size       = 4,
    parameter bit buffered   = 0
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   push,
    input  wire                   pop,
    input  wire  [data_width-1:0] data_in,
    output logic [data_width-1:0] data_out,
    output logic                  empty,
    output logic                  full
);

    logic reading;
    logic writing;

    // requests into a full queue and pops from an empty one are dropped here
    assign reading = pop && !empty;
    assign writing = push && !full;

    if (size == 1) begin : g_single

        logic [data_width-1:0] head_r;
        logic                  valid_r;

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_r <= 1'b0;
            end else if (writing) begin
                valid_r <= 1'b1;
            end else if (reading) begin
                valid_r <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (writing) begin
                head_r <= data_in;
            end
        end

        assign data_out = head_r;
        assign empty    = !valid_r;
        assign full     = valid_r;

    end else begin : g_multi

        localparam int addr_bits = $clog2(size);

        logic [data_width-1:0] mem [size];

        if (!buffered) begin : g_plain

            // pointers carry an extra wrap bit to tell full from empty
            logic [addr_bits:0] rd_ptr_r;
            logic [addr_bits:0] wr_ptr_r;

            always_ff @(posedge clk) begin
                if (reset) begin
                    rd_ptr_r <= '0;
                    wr_ptr_r <= '0;
                end else begin
                    if (writing) begin
                        wr_ptr_r <= wr_ptr_r + 1'b1;
                    end
                    if (reading) begin
                        rd_ptr_r <= rd_ptr_r + 1'b1;
                    end
                end
            end

            always_ff @(posedge clk) begin
                if (writing) begin
                    mem[wr_ptr_r[addr_bits-1:0]] <= data_in;
                end
            end

            assign data_out = mem[rd_ptr_r[addr_bits-1:0]];
            assign empty    = (rd_ptr_r == wr_ptr_r);
            assign full     = (rd_ptr_r[addr_bits-1:0] == wr_ptr_r[addr_bits-1:0])
                           && (rd_ptr_r[addr_bits] != wr_ptr_r[addr_bits]);

        end else begin : g_buffered

            logic [addr_bits-1:0]  wr_ptr_r;
            logic [addr_bits-1:0]  rd_ptr_r;
            logic [addr_bits-1:0]  rd_next_r;
            logic [addr_bits:0]    count_r;
            logic                  empty_r;
            logic                  full_r;
            logic                  bypass_r;
            logic [data_width-1:0] head_r;
            logic [data_width-1:0] curr_r;

            always_ff @(posedge clk) begin
                if (reset) begin
                    wr_ptr_r  <= '0;
                    rd_ptr_r  <= '0;
                    rd_next_r <= addr_bits'(1);
                    count_r   <= '0;
                    empty_r   <= 1'b1;
                    full_r    <= 1'b0;
                    bypass_r  <= 1'b0;
                end else begin
                    if (writing) begin
                        wr_ptr_r <= wr_ptr_r + 1'b1;
                    end
                    if (reading) begin
                        rd_ptr_r  <= rd_next_r;
                        rd_next_r <= rd_next_r + 1'b1;
                    end

                    if (writing && !reading) begin
                        count_r <= count_r + 1'b1;
                        empty_r <= 1'b0;
                        full_r  <= (count_r == (addr_bits + 1)'(size - 1));
                    end else if (reading && !writing) begin
                        count_r <= count_r - 1'b1;
                        empty_r <= (count_r == (addr_bits + 1)'(1));
                        full_r  <= 1'b0;
                    end

                    // new entry becomes the head when queue is empty or about to be
                    bypass_r <= writing
                             && (empty_r || (reading && (count_r == (addr_bits + 1)'(1))));
                end
            end

            always_ff @(posedge clk) begin
                if (writing) begin
                    mem[wr_ptr_r] <= data_in;
                end
                curr_r <= data_in;
                head_r <= mem[reading ? rd_next_r : rd_ptr_r];
            end

            assign data_out = bypass_r ? curr_r : head_r;
            assign empty    = empty_r;
            assign full     = full_r;

        end
    end

endmodule

`default_nettype wire

// File: source/request_port.sv
`timescale 1ns/1ns
`default_nettype none

module request_port #(
    parameter int queue_size     = 4,
    parameter bit queue_buffered = 0
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    req_strobe,
    input  wire                    req_write,
    input  wire hub_mem_pkg::req_word_t req_word,
    input  wire                    grant,
    output logic                   queue_empty,
    output logic                   head_write,
    output hub_mem_pkg::req_word_t head_word,
    output logic                   overflow
);
    import hub_mem_pkg::*;

    logic [queue_width-1:0] queue_in;
    logic [queue_width-1:0] queue_out;
    logic                   queue_full;

    // op bit rides at the top of the entry
    assign queue_in   = {req_write, req_word};
    assign head_write = queue_out[queue_width-1];
    assign head_word  = queue_out[queue_width-2:0];

    request_queue #(
        .data_width (queue_width),
        .size       (queue_size),
        .buffered   (queue_buffered)
    ) u_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (req_strobe),
        .pop      (grant),
        .data_in  (queue_in),
        .data_out (queue_out),
        .empty    (queue_empty),
        .full     (queue_full)
    );

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            overflow <= 1'b0;
        end else if (req_strobe && queue_full) begin
            overflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/rr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module rr_arbiter (
    input  wire                                     clk,
    input  wire                                     reset,
    input  wire                                     queue_empty_0,
    input  wire                                     queue_empty_1,
    output logic                                    grant_0,
    output logic                                    grant_1,
    output logic [hub_cfg_pkg::port_idx_width-1:0] grant_port
);
    import hub_cfg_pkg::*;

    logic [num_ports-1:0]      requests;
    logic [num_ports-1:0]      grants;
    logic [port_idx_width-1:0] last_r;

    assign requests = {!queue_empty_1, !queue_empty_0};

    always_comb begin
        if (&requests) begin
            // both waiting so hand over to the port not served last
            grant_port = (last_r == port_idx_width'(0)) ? port_idx_width'(1)
                                                        : port_idx_width'(0);
        end else if (requests[1]) begin
            grant_port = port_idx_width'(1);
        end else begin
            grant_port = '0;
        end
        grants             = '0;
        grants[grant_port] = |requests;
    end

    // start as if the last port was served so port 0 wins the first tie
    always_ff @(posedge clk) begin
        if (reset) begin
            last_r <= port_idx_width'(num_ports - 1);
        end else if (|requests) begin
            last_r <= grant_port;
        end
    end

    assign grant_0 = grants[0];
    assign grant_1 = grants[1];

endmodule

`default_nettype wire

// File: source/scratchpad_bank.sv
`timescale 1ns/1ns
`default_nettype none

module scratchpad_bank (
    input  wire                                     clk,
    input  wire                                     reset,
    input  wire                                     cmd_strobe,
    input  wire                                     cmd_write,
    input  wire hub_mem_pkg::req_word_t            cmd_word,
    input  wire  [hub_cfg_pkg::port_idx_width-1:0] cmd_port,
    output logic                                    rsp_strobe,
    output logic [hub_cfg_pkg::port_idx_width-1:0] rsp_port,
    output logic [hub_mem_pkg::tag_width-1:0]      rsp_tag,
    output logic [hub_mem_pkg::data_width-1:0]     rsp_data
);
    import hub_mem_pkg::*;

    logic [data_width-1:0] mem [2**addr_width];
    logic                  do_write;
    logic                  do_read;

    assign do_write = cmd_strobe && cmd_write;
    assign do_read  = cmd_strobe && !cmd_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_strobe <= 1'b0;
        end else begin
            rsp_strobe <= do_read;
        end
    end

    // --------------------
    // storage and read path
    // --------------------

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[cmd_word.wr.addr] <= cmd_word.wr.data;
        end
        if (do_read) begin
            rsp_data <= mem[cmd_word.rd.addr];
            rsp_tag  <= cmd_word.rd.tag;
            rsp_port <= cmd_port;
        end
    end

endmodule

`default_nettype wire

// File: source/mem_hub_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_hub_top #(
    parameter int queue_size     = 4,
    parameter bit queue_buffered = 0
) (
    input  wire                                     clk,
    input  wire                                     reset,
    input  wire                                     req_strobe_0,
    input  wire                                     req_write_0,
    input  wire hub_mem_pkg::req_word_t            req_word_0,
    input  wire                                     req_strobe_1,
    input  wire                                     req_write_1,
    input  wire hub_mem_pkg::req_word_t            req_word_1,
    output logic                                    rsp_strobe,
    output logic [hub_cfg_pkg::port_idx_width-1:0] rsp_port,
    output logic [hub_mem_pkg::tag_width-1:0]      rsp_tag,
    output logic [hub_mem_pkg::data_width-1:0]     rsp_data,
    output logic                                    overflow_0,
    output logic                                    overflow_1
);
    import hub_cfg_pkg::*;
    import hub_mem_pkg::*;

    logic                      queue_empty_0;
    logic                      queue_empty_1;
    logic                      head_write_0;
    logic                      head_write_1;
    req_word_t                 head_word_0;
    req_word_t                 head_word_1;
    logic                      grant_0;
    logic                      grant_1;
    logic [port_idx_width-1:0] grant_port;
    logic                      cmd_strobe;
    logic                      cmd_write;
    req_word_t                 cmd_word;

    request_port #(
        .queue_size     (queue_size),
        .queue_buffered (queue_buffered)
    ) u_port_0 (
        .clk         (clk),
        .reset       (reset),
        .req_strobe  (req_strobe_0),
        .req_write   (req_write_0),
        .req_word    (req_word_0),
        .grant       (grant_0),
        .queue_empty (queue_empty_0),
        .head_write  (head_write_0),
        .head_word   (head_word_0),
        .overflow    (overflow_0)
    );

    request_port #(
        .queue_size     (queue_size),
        .queue_buffered (queue_buffered)
    ) u_port_1 (
        .clk         (clk),
        .reset       (reset),
        .req_strobe  (req_strobe_1),
        .req_write   (req_write_1),
        .req_word    (req_word_1),
        .grant       (grant_1),
        .queue_empty (queue_empty_1),
        .head_write  (head_write_1),
        .head_word   (head_word_1),
        .overflow    (overflow_1)
    );

    rr_arbiter u_arbiter (
        .clk           (clk),
        .reset         (reset),
        .queue_empty_0 (queue_empty_0),
        .queue_empty_1 (queue_empty_1),
        .grant_0       (grant_0),
        .grant_1       (grant_1),
        .grant_port    (grant_port)
    );

    // granted head goes to the scratchpad
    assign cmd_strobe = grant_0 || grant_1;
    assign cmd_write  = (grant_port == port_idx_width'(1)) ? head_write_1 : head_write_0;
    assign cmd_word   = (grant_port == port_idx_width'(1)) ? head_word_1 : head_word_0;

    scratchpad_bank u_scratchpad (
        .clk        (clk),
        .reset      (reset),
        .cmd_strobe (cmd_strobe),
        .cmd_write  (cmd_write),
        .cmd_word   (cmd_word),
        .cmd_port   (grant_port),
        .rsp_strobe (rsp_strobe),
        .rsp_port   (rsp_port),
        .rsp_tag    (rsp_tag),
        .rsp_data   (rsp_data)
    );

endmodule

`default_nettype wire

// File: verification/mem_hub_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_hub_tb #(
    parameter int queue_size     = 4,
    parameter bit queue_buffered = 0
);
    import hub_mem_pkg::*;

    localparam int max_requests = 64;
    localparam int fields       = 6;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        req_strobe_0;
    logic        req_write_0;
    req_word_t   req_word_0;
    logic        req_strobe_1;
    logic        req_write_1;
    req_word_t   req_word_1;
    logic        rsp_strobe;
    logic        rsp_port;
    logic [7:0]  rsp_tag;
    logic [15:0] rsp_data;
    logic        overflow_0;
    logic        overflow_1;

    // one line per request with port op addr data_or_tag expected idle
    logic [15:0]  stim [fields*max_requests];
    // expected reads per port as {tag, data}
    logic [23:0]  expect_0 [$];
    logic [23:0]  expect_1 [$];
    logic [255:0] flood_tags [2];
    int           flood_last [2];
    logic         flooding = 1'b0;
    int           value_errors = 0;
    int           other_errors = 0;
    int           seed = 32'h26cf_d46a;

    mem_hub_top #(
        .queue_size     (queue_size),
        .queue_buffered (queue_buffered)
    ) UUT (
        .clk          (clk),
        .reset        (reset),
        .req_strobe_0 (req_strobe_0),
        .req_write_0  (req_write_0),
        .req_word_0   (req_word_0),
        .req_strobe_1 (req_strobe_1),
        .req_write_1  (req_write_1),
        .req_word_1   (req_word_1),
        .rsp_strobe   (rsp_strobe),
        .rsp_port     (rsp_port),
        .rsp_tag      (rsp_tag),
        .rsp_data     (rsp_data),
        .overflow_0   (overflow_0),
        .overflow_1   (overflow_1)
    );

    always #2 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("Error %s: got %h expected %h", name, got, expected);
            value_errors++;
        end
    endtask

    task automatic set_port(input int port, input logic strobe, input logic write,
                            input req_word_t word);
        if (port == 0) begin
            req_strobe_0 = strobe;
            req_write_0  = write;
            req_word_0   = word;
        end else begin
            req_strobe_1 = strobe;
            req_write_1  = write;
            req_word_1   = word;
        end
    endtask

    // --------------------
    // response scoreboard
    // --------------------

    task automatic check_response();
        int          pending;
        logic [23:0] expected;
        pending = rsp_port ? expect_1.size() : expect_0.size();
        if (flooding) begin
            assert (flood_tags[rsp_port][rsp_tag]) else begin
                $display("response on port %0d carries tag %h that was never issued",
                         rsp_port, rsp_tag);
                other_errors++;
            end
            // flood tags rise with issue order on each port
            assert (int'(rsp_tag) > flood_last[rsp_port]) else begin
                $display("response on port %0d returned tag %h out of issue order",
                         rsp_port, rsp_tag);
                other_errors++;
            end
            flood_last[rsp_port] = int'(rsp_tag);
        end else begin
            assert (pending > 0) else begin
                $display("response on port %0d with no read outstanding", rsp_port);
                other_errors++;
            end
            if (pending > 0) begin
                if (rsp_port) begin
                    expected = expect_1.pop_front();
                end else begin
                    expected = expect_0.pop_front();
                end
                check_value("rsp_tag", 32'(rsp_tag), 32'(expected[23:16]));
                check_value("rsp_data", 32'(rsp_data), 32'(expected[15:0]));
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset && rsp_strobe) begin
            check_response();
        end
    end

    // --------------------
    // stimulus
    // --------------------

    task automatic drive_port(input int port);
        int        gap;
        int        base;
        req_word_t word;
        for (int i = 0; i < max_requests; i++) begin
            base = fields * i;
            if (stim[base] == 16'hffff) begin
                break;
            end
            if (int'(stim[base]) == port) begin
                word = '0;
                if (stim[base+1][0]) begin
                    word.wr.addr = stim[base+2][7:0];
                    word.wr.data = stim[base+3];
                end else begin
                    word.rd.addr = stim[base+2][7:0];
                    word.rd.tag  = stim[base+3][7:0];
                    if (port == 0) begin
                        expect_0.push_back({stim[base+3][7:0], stim[base+4]});
                    end else begin
                        expect_1.push_back({stim[base+3][7:0], stim[base+4]});
                    end
                end
                set_port(port, 1'b1, stim[base+1][0], word);
                next_cycle();
                set_port(port, 1'b0, 1'b0, '0);
                // jittered idle gap
                gap = int'(stim[base+5]) + ($random(seed) & 3);
                repeat (gap) next_cycle();
            end
        end
    endtask

    task automatic flood_both_ports();
        req_word_t word;
        flooding = 1'b1;
        for (int i = 0; i < 32; i++) begin
            word         = '0;
            word.rd.addr = 8'h10;
            word.rd.tag  = 8'h80 + 8'(i);
            flood_tags[0][word.rd.tag] = 1'b1;
            set_port(0, 1'b1, 1'b0, word);
            word.rd.addr = 8'h11;
            word.rd.tag  = 8'hc0 + 8'(i);
            flood_tags[1][word.rd.tag] = 1'b1;
            set_port(1, 1'b1, 1'b0, word);
            next_cycle();
        end
        set_port(0, 1'b0, 1'b0, '0);
        set_port(1, 1'b0, 1'b0, '0);
    endtask

    initial begin
        int cycles;
        int quiet;
        set_port(0, 1'b0, 1'b0, '0);
        set_port(1, 1'b0, 1'b0, '0);
        flood_tags[0] = '0;
        flood_tags[1] = '0;
        flood_last[0] = -1;
        flood_last[1] = -1;
        foreach (stim[i]) begin
            stim[i] = 16'hffff;
        end
        $readmemh("verification/mem_hub_input.txt", stim);

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // nothing may come out before the first request
        repeat (4) begin
            @(negedge clk);
            check_value("rsp_strobe", 32'(rsp_strobe), 32'h0);
            check_value("overflow_0", 32'(overflow_0), 32'h0);
            check_value("overflow_1", 32'(overflow_1), 32'h0);
        end

        next_cycle();
        fork
            drive_port(0);
            drive_port(1);
        join

        cycles = 0;
        while ((expect_0.size() != 0 || expect_1.size() != 0) && cycles < 400) begin
            next_cycle();
            cycles++;
        end
        assert (cycles < 400) else begin
            $display("timed out waiting for read responses, %0d and %0d still missing",
                     expect_0.size(), expect_1.size());
            other_errors++;
        end

        flood_both_ports();
        quiet  = 0;
        cycles = 0;
        while (quiet < 8 && cycles < 200) begin
            next_cycle();
            quiet = rsp_strobe ? 0 : quiet + 1;
            cycles++;
        end
        assert (quiet >= 8) else begin
            $display("responses did not stop after the flood");
            other_errors++;
        end
        check_value("overflow_0", 32'(overflow_0), 32'h1);
        check_value("overflow_1", 32'(overflow_1), 32'h1);

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/mem_hub_input.txt
// port op(1 write) addr data_or_tag expected_read_data idle_cycles, all hex
// port 0 uses even addresses and port 1 odd ones
0 1 10 a5a5 0000 2
1 1 11 5a5a 0000 2
0 0 10 0001 a5a5 2
1 0 11 0041 5a5a 2
0 1 20 1234 0000 2
0 1 22 beef 0000 3
1 1 21 cafe 0000 2
1 1 23 0f0f 0000 2
0 0 22 0002 beef 2
0 0 20 0003 1234 2
1 0 23 0042 0f0f 2
1 0 21 0043 cafe 2
0 1 20 7777 0000 2
0 0 20 0004 7777 2
1 1 11 8001 0000 4
1 0 11 0044 8001 2
0 0 10 0005 a5a5 2
1 0 23 0045 0f0f 2
0 1 fe ffff 0000 2
0 0 fe 0006 ffff 2
1 1 ff 0000 0000 2
1 0 ff 0046 0000 2

// File: mem_hub.f
source/hub_cfg_pkg.sv
source/hub_mem_pkg.sv
source/request_queue.sv
source/request_port.sv
source/rr_arbiter.sv
source/scratchpad_bank.sv
source/mem_hub_top.sv
verification/mem_hub_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# two builds: default queues, then single-entry buffered queues
cd "$(dirname "$0")" || exit 1

run_build() {
    local dir=$1
    local out
    shift
    verilator --binary --timing --assert -Wno-fatal --top-module mem_hub_tb \
        -f mem_hub.f --Mdir "$dir" "$@" || return 1
    out=$("./$dir/Vmem_hub_tb")
    echo "$out"
    echo "$out" | grep -qx "Test passed"
}

run_build obj_default && run_build obj_single -Gqueue_size=1 -Gqueue_buffered=1 && exit 0 || exit 1
